//--- flist.f
hdl/fetch_pkg.sv
hdl/imem_bank_router.sv
hdl/imem_bank.sv
hdl/imem_response_merge.sv
hdl/instruction_fetch.sv
hdl/jump_predecode.sv
hdl/fetch_subsystem.sv
test/tb_clock_gen.sv
test/tb_fetch_subsystem.sv

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // RV32 base widths
    localparam int iwidth   = 32;
    localparam int pc_width = 32;

    // Opcodes the predecoder acts on
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // One instruction word, seen as J-type or B-type
    typedef union packed {
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_view;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
    } instr_word_u;

endpackage

//--- hdl/fetch_subsystem.sv
module fetch_subsystem #(
    parameter int num_banks  = 4,
    parameter int bank_depth = 64
) (
    input  logic                           f_clk,
    input  logic                           f_rst,
    input  logic                           fetch_en,
    input  logic                           stall,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::pc_width-1:0] redirect_pc,
    input  logic                           load_we,
    input  logic [fetch_pkg::pc_width-1:0] load_addr,
    input  logic [fetch_pkg::iwidth-1:0]   load_data,
    output logic                           out_valid,
    output logic [fetch_pkg::iwidth-1:0]   out_instr,
    output logic [fetch_pkg::pc_width-1:0] out_addr
);
    import fetch_pkg::*;

    localparam int idx_bits = $clog2(bank_depth);

    // Fetch side
    logic                req;
    logic [pc_width-1:0] req_addr;
    logic                ack;
    logic [iwidth-1:0]   instr;

    // Bank side
    logic [num_banks-1:0] bank_rd;
    logic [num_banks-1:0] bank_we;
    logic [idx_bits-1:0]  bank_index;
    logic [iwidth-1:0]    bank_wdata;
    logic [num_banks-1:0] bank_ack;
    logic [iwidth-1:0]    bank_data [num_banks];

    // Redirects
    logic                pd_redirect;
    logic [pc_width-1:0] pd_target;
    logic                fetch_redirect;
    logic [pc_width-1:0] fetch_redirect_pc;

    imem_bank_router #(
        .num_banks  (num_banks),
        .bank_depth (bank_depth)
    ) u_router (
        .f_clk      (f_clk),
        .f_rst      (f_rst),
        .req        (req),
        .req_addr   (req_addr),
        .ack        (ack),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .bank_rd    (bank_rd),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_wdata (bank_wdata)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        imem_bank #(
            .bank_depth (bank_depth)
        ) u_bank (
            .f_clk     (f_clk),
            .f_rst     (f_rst),
            .rd        (bank_rd[b]),
            .we        (bank_we[b]),
            .index     (bank_index),
            .wdata     (bank_wdata),
            .bank_ack  (bank_ack[b]),
            .bank_data (bank_data[b])
        );
    end

    imem_response_merge #(
        .num_banks (num_banks)
    ) u_merge (
        .f_clk     (f_clk),
        .f_rst     (f_rst),
        .bank_ack  (bank_ack),
        .bank_data (bank_data),
        .ack       (ack),
        .instr     (instr)
    );

    // External redirect wins over the predecoder
    assign fetch_redirect    = redirect_valid || pd_redirect;
    assign fetch_redirect_pc = redirect_valid ? redirect_pc : pd_target;

    instruction_fetch u_fetch (
        .f_clk          (f_clk),
        .f_rst          (f_rst),
        .fetch_en       (fetch_en),
        .stall          (stall),
        .ack            (ack),
        .instr          (instr),
        .redirect_valid (fetch_redirect),
        .redirect_pc    (fetch_redirect_pc),
        .req            (req),
        .req_addr       (req_addr),
        .out_valid      (out_valid),
        .out_instr      (out_instr),
        .out_addr       (out_addr)
    );

    jump_predecode u_predecode (
        .out_valid   (out_valid),
        .out_instr   (out_instr),
        .out_addr    (out_addr),
        .pd_redirect (pd_redirect),
        .pd_target   (pd_target)
    );

endmodule

//--- hdl/imem_bank.sv
module imem_bank #(
    parameter int bank_depth = 64
) (
    input  logic                          f_clk,
    input  logic                          f_rst,
    input  logic                          rd,
    input  logic                          we,
    input  logic [$clog2(bank_depth)-1:0] index,
    input  logic [fetch_pkg::iwidth-1:0]  wdata,
    output logic                          bank_ack,
    output logic [fetch_pkg::iwidth-1:0]  bank_data
);
    import fetch_pkg::*;

    localparam int idx_bits = $clog2(bank_depth);

    logic [iwidth-1:0]   mem [bank_depth];
    logic                rd_q;
    logic [idx_bits-1:0] index_q;

    always_ff @(posedge f_clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // Read strobe pipeline, ack one cycle after the registered read
    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            rd_q     <= 1'b0;
            bank_ack <= 1'b0;
        end
        else begin
            rd_q     <= rd;
            bank_ack <= rd_q;
        end
    end

    always_ff @(posedge f_clk) begin
        if (rd) begin
            index_q <= index;
        end
        if (rd_q) begin
            bank_data <= mem[index_q];
        end
    end

endmodule

//--- hdl/imem_bank_router.sv
module imem_bank_router #(
    parameter int num_banks  = 4,
    parameter int bank_depth = 64
) (
    input  logic                                f_clk,
    input  logic                                f_rst,
    input  logic                                req,
    input  logic [fetch_pkg::pc_width-1:0]      req_addr,
    input  logic                                ack,
    input  logic                                load_we,
    input  logic [fetch_pkg::pc_width-1:0]      load_addr,
    input  logic [fetch_pkg::iwidth-1:0]        load_data,
    output logic [num_banks-1:0]                bank_rd,
    output logic [num_banks-1:0]                bank_we,
    output logic [$clog2(bank_depth)-1:0]       bank_index,
    output logic [fetch_pkg::iwidth-1:0]        bank_wdata
);
    localparam int sel_bits = $clog2(num_banks);
    localparam int idx_bits = $clog2(bank_depth);

    logic                issued;
    logic                issue;
    logic [sel_bits-1:0] rd_sel;
    logic [sel_bits-1:0] wr_sel;

    // Word index low bits pick the bank
    assign rd_sel = req_addr[2 +: sel_bits];
    assign wr_sel = load_addr[2 +: sel_bits];

    // First cycle of a request only; a preload write holds it off
    assign issue = req && !issued && !load_we;

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            issued <= 1'b0;
        end
        else if (ack) begin
            issued <= 1'b0;
        end
        else if (issue) begin
            issued <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < num_banks; i++) begin
            bank_rd[i] = issue && (rd_sel == sel_bits'(i));
            bank_we[i] = load_we && (wr_sel == sel_bits'(i));
        end
    end

    // Shared index bus, writes first
    assign bank_index = load_we ? load_addr[2 + sel_bits +: idx_bits]
                                : req_addr[2 + sel_bits +: idx_bits];
    assign bank_wdata = load_data;

    rd_onehot: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        $onehot0(bank_rd)
    ) else $error("more than one bank read at once: %b", bank_rd);

endmodule

//--- hdl/imem_response_merge.sv
module imem_response_merge #(
    parameter int num_banks = 4
) (
    input  logic                         f_clk,
    input  logic                         f_rst,
    input  logic [num_banks-1:0]         bank_ack,
    input  logic [fetch_pkg::iwidth-1:0] bank_data [num_banks],
    output logic                         ack,
    output logic [fetch_pkg::iwidth-1:0] instr
);

    assign ack = |bank_ack;

    // AND-OR mux; only the acking bank contributes
    always_comb begin
        instr = '0;
        for (int i = 0; i < num_banks; i++) begin
            if (bank_ack[i]) begin
                instr = instr | bank_data[i];
            end
        end
    end

    ack_onehot: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        $onehot0(bank_ack)
    ) else $error("several banks acked in one cycle: %b", bank_ack);

endmodule

//--- hdl/instruction_fetch.sv
module instruction_fetch (
    input  logic                           f_clk,
    input  logic                           f_rst,
    input  logic                           fetch_en,
    input  logic                           stall,
    input  logic                           ack,
    input  logic [fetch_pkg::iwidth-1:0]   instr,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::pc_width-1:0] redirect_pc,
    output logic                           req,
    output logic [fetch_pkg::pc_width-1:0] req_addr,
    output logic                           out_valid,
    output logic [fetch_pkg::iwidth-1:0]   out_instr,
    output logic [fetch_pkg::pc_width-1:0] out_addr
);
    import fetch_pkg::*;

    localparam logic [pc_width-1:0] reset_pc = '0;

    // Address of the request in flight, or of the next one to raise
    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] pc_next;

    // Two bits, since up to two redirects can land during one request
    logic [1:0] epoch;
    logic [1:0] epoch_next;
    logic [1:0] req_epoch;

    // Output slot holding one fetched word
    logic pend;

    logic stale;
    logic slot_free;
    logic take;

    // Response from an older path, or one that a redirect overtakes now
    assign stale     = (req_epoch != epoch) || redirect_valid;
    // Slot empty, or its word goes out this cycle
    assign slot_free = !pend || !stall;
    assign take      = req && ack && !stale && slot_free;

    assign epoch_next = redirect_valid ? epoch + 2'd1 : epoch;

    always_comb begin
        pc_next = pc;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end
        else if (take) begin
            pc_next = pc + pc_width'(4);
        end
    end

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            pc        <= reset_pc;
            epoch     <= 2'd0;
            req_epoch <= 2'd0;
            req       <= 1'b0;
            req_addr  <= reset_pc;
            pend      <= 1'b0;
        end
        else begin
            pc    <= pc_next;
            epoch <= epoch_next;

            // req stays up until ack, then the next one follows right away
            if (!req || ack) begin
                req       <= fetch_en && !stall;
                req_addr  <= pc_next;
                req_epoch <= epoch_next;
            end

            if (take) begin
                pend <= 1'b1;
            end
            else if (redirect_valid || !stall) begin
                pend <= 1'b0;
            end
        end
    end

    // Word and its address; a full slot at ack means a replay of pc
    always_ff @(posedge f_clk) begin
        if (take) begin
            out_instr <= instr;
            out_addr  <= req_addr;
        end
    end

    assign out_valid = pend && !stall;

    req_addr_hold: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        req && !ack |=> req && $stable(req_addr)
    ) else $error("req_addr changed while a request waited for ack");

endmodule

//--- hdl/jump_predecode.sv
module jump_predecode (
    input  logic                           out_valid,
    input  logic [fetch_pkg::iwidth-1:0]   out_instr,
    input  logic [fetch_pkg::pc_width-1:0] out_addr,
    output logic                           pd_redirect,
    output logic [fetch_pkg::pc_width-1:0] pd_target
);
    import fetch_pkg::*;

    instr_word_u         word;
    logic [pc_width-1:0] j_imm;
    logic [pc_width-1:0] b_imm;
    logic                is_jal;
    logic                is_back_branch;

    assign word = out_instr;

    // J immediate, bit 0 implied zero
    assign j_imm = {{(pc_width - 21){word.j_view.imm20}},
                    word.j_view.imm20,
                    word.j_view.imm19_12,
                    word.j_view.imm11,
                    word.j_view.imm10_1,
                    1'b0};

    // B immediate
    assign b_imm = {{(pc_width - 13){word.b_view.imm12}},
                    word.b_view.imm12,
                    word.b_view.imm11,
                    word.b_view.imm10_5,
                    word.b_view.imm4_1,
                    1'b0};

    assign is_jal = word.j_view.opcode == opcode_jal;

    // Static prediction, taken only when the offset is negative
    assign is_back_branch = (word.b_view.opcode == opcode_branch) && word.b_view.imm12;

    assign pd_redirect = out_valid && (is_jal || is_back_branch);
    assign pd_target   = out_addr + (is_jal ? j_imm : b_imm);

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 10
) (
    output logic f_clk,
    output logic f_rst
);

    initial begin
        f_clk = 1'b0;
        forever #(period / 2) f_clk = ~f_clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        f_rst = 1'b0;
        repeat (reset_cycles) @(posedge f_clk);
        f_rst <= 1'b1;
    end

endmodule

//--- test/tb_fetch_subsystem.sv
module tb_fetch_subsystem;

    localparam int num_banks  = 4;
    localparam int bank_depth = 64;
    localparam int num_words  = num_banks * bank_depth;
    localparam int addr_bits  = $clog2(num_words) + 2;

    localparam int preload_cycles = num_words;
    localparam int run_cycles     = 1500;
    localparam int timeout_cycles = 2 * (preload_cycles + run_cycles);
    // Roughly 3 cycles per word plus stalls and redirect refetches
    localparam int run_outputs    = run_cycles / 5;

    localparam logic [6:0] op_jal    = 7'h6f;
    localparam logic [6:0] op_branch = 7'h63;
    localparam logic [6:0] op_alu    = 7'h13;

    // What predicts the next output address
    localparam int k_seq  = 0;
    localparam int k_fwd  = 1;
    localparam int k_jal  = 2;
    localparam int k_back = 3;
    localparam int k_ext  = 4;

    localparam logic [31:0] loop_branch_addr = 32'h0000_00a0;
    localparam int          loop_iterations  = 3;

    logic        f_clk;
    logic        f_rst;
    logic        fetch_en;
    logic        stall;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        out_valid;
    logic [31:0] out_instr;
    logic [31:0] out_addr;

    logic [31:0] model_mem [num_words];
    logic [31:0] expected_word;
    logic [31:0] exp_addr;
    int          exp_kind;
    int          n_out = 0;
    int          n_kind [5] = '{default: 0};
    int          loop_count = 0;
    int          cycle_count = 0;

    tb_clock_gen #(
        .period       (8),
        .reset_cycles (10)
    ) u_clock_gen (
        .f_clk (f_clk),
        .f_rst (f_rst)
    );

    fetch_subsystem #(
        .num_banks  (num_banks),
        .bank_depth (bank_depth)
    ) DUT (
        .f_clk          (f_clk),
        .f_rst          (f_rst),
        .fetch_en       (fetch_en),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .load_we        (load_we),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .out_valid      (out_valid),
        .out_instr      (out_instr),
        .out_addr       (out_addr)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("ERROR %s: expected %h, actual %h", test, expected, actual));
    endtask

    // RV32 J and B encodings, rd x1, rs1 x1, rs2 x2
    function automatic logic [31:0] encode_jal(input int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op_jal};
    endfunction

    function automatic logic [31:0] encode_branch(input int offset);
        logic [12:0] imm;
        imm = offset[12:0];
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic int word_kind(input logic [31:0] w);
        if (w[6:0] == op_jal) begin
            return k_jal;
        end
        if (w[6:0] == op_branch) begin
            return w[31] ? k_back : k_fwd;
        end
        return k_seq;
    endfunction

    task automatic build_program();
        logic [31:0] w;
        for (int i = 0; i < num_words; i++) begin
            w = $urandom();
            if (w[6:0] == op_jal || w[6:0] == op_branch) begin
                w[6:0] = op_alu;
            end
            model_mem[i] = w;
        end
        model_mem[8]   = encode_jal(32'h40);
        model_mem[30]  = encode_branch(32'h100);
        model_mem[40]  = encode_branch(-32'sh20);
        // Both wrap back to word 0 inside the loaded range
        model_mem[120] = encode_jal(-120 * 4);
        model_mem[255] = encode_jal(-255 * 4);
    endtask

    assign expected_word = model_mem[out_addr[addr_bits-1:2]];

    // Reference model of the next output address
    always @(posedge f_clk) begin
        if (!f_rst) begin
            exp_addr <= '0;
            exp_kind <= k_seq;
        end
        else begin
            if (out_valid) begin
                n_out            <= n_out + 1;
                n_kind[exp_kind] <= n_kind[exp_kind] + 1;
            end
            if (redirect_valid) begin
                exp_addr <= redirect_pc;
                exp_kind <= k_ext;
            end
            else if (out_valid) begin
                exp_kind <= word_kind(out_instr);
                case (word_kind(out_instr))
                    k_jal:   exp_addr <= out_addr + jal_offset(out_instr);
                    k_back:  exp_addr <= out_addr + branch_offset(out_instr);
                    default: exp_addr <= out_addr + 32'd4;
                endcase
            end
        end
    end

    // Random stall and redirects, plus the loop exit
    always @(posedge f_clk) begin
        if (fetch_en) begin
            stall          <= ($urandom_range(7, 0) == 0);
            redirect_valid <= 1'b0;
            if (out_valid && out_addr == loop_branch_addr) begin
                if (loop_count == loop_iterations - 1) begin
                    loop_count     <= 0;
                    redirect_valid <= 1'b1;
                    redirect_pc    <= out_addr + 32'd4;
                end
                else begin
                    loop_count <= loop_count + 1;
                end
            end
            else if ($urandom_range(63, 0) == 0) begin
                redirect_valid <= 1'b1;
                redirect_pc    <= 32'($urandom_range(num_words - 1, 0)) << 2;
            end
        end
    end

    always @(posedge f_clk) begin
        if (cycle_count >= timeout_cycles) begin
            abort_run("Timeout: fetch stopped producing instructions");
        end
        else begin
            cycle_count <= cycle_count + 1;
        end
    end

    idle_until_enable: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        !fetch_en |-> !out_valid
    ) else report_mismatch("idle_until_enable", 32'd0, 32'($sampled(out_valid)));

    quiet_under_stall: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        stall |-> !out_valid
    ) else report_mismatch("quiet_under_stall", 32'd0, 32'($sampled(out_valid)));

    word_from_memory: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        out_valid |-> out_instr == expected_word
    ) else report_mismatch("word_from_memory", $sampled(expected_word), $sampled(out_instr));

    addr_sequential: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        out_valid && (exp_kind == k_seq || exp_kind == k_fwd) |-> out_addr == exp_addr
    ) else report_mismatch("addr_sequential", $sampled(exp_addr), $sampled(out_addr));

    addr_jump: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        out_valid && (exp_kind == k_jal || exp_kind == k_back) |-> out_addr == exp_addr
    ) else report_mismatch("addr_jump", $sampled(exp_addr), $sampled(out_addr));

    addr_redirect: assert property (
        @(posedge f_clk) disable iff (!f_rst)
        out_valid && exp_kind == k_ext |-> out_addr == exp_addr
    ) else report_mismatch("addr_redirect", $sampled(exp_addr), $sampled(out_addr));

    initial begin : main_flow
        int unsigned seed_word;
        seed_word      = $urandom(32'h0758_e4d0);
        fetch_en       = 1'b0;
        stall          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_we        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        build_program();

        wait (f_rst === 1'b1);
        @(posedge f_clk);
        for (int i = 0; i < num_words; i++) begin
            load_we   <= 1'b1;
            load_addr <= 32'(i) << 2;
            load_data <= model_mem[i];
            @(posedge f_clk);
        end
        load_we <= 1'b0;
        @(posedge f_clk);
        fetch_en <= 1'b1;

        while (n_out < run_outputs) begin
            @(posedge f_clk);
        end

        if (n_kind[k_fwd] == 0 || n_kind[k_jal] == 0 || n_kind[k_back] == 0 ||
            n_kind[k_ext] == 0) begin
            abort_run("A jump, branch or external redirect case was never exercised");
        end
        else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
